// ==== tb_usb_tx_top.sv ====
//////////////////////////////
// Testbench for the USB full-speed transmit path
// Decodes the pads back to bits, ClkPerBit must be 4 or more
//////////////////////////////

`timescale 1ns/1ps

module tb_usb_tx_top;

  localparam int ClkPerBit = 4;
  localparam int FifoDepth = 16;
  localparam int WaitLimit = 2000;

  logic              clk_i;
  logic              rst_ni;
  logic              link_reset_i;
  logic              cfg_pinflip_i;
  logic              tx_osc_test_mode_i;
  logic              wr_valid_i;
  usb_tx_pkg::byte_t wr_data_i;
  logic              wr_ready_o;
  logic              pkt_start_i;
  usb_tx_pkg::pid_t  pid_i;
  logic              pkt_end_o;
  logic              usb_oe_o;
  logic              usb_d_o;
  logic              usb_se0_o;
  logic              usb_dp_o;
  logic              usb_dn_o;

  int                err_cnt;
  int                test_err;
  int                test_cnt;
  int                test_fail;
  int                end_pulses;
  string             test_name;
  usb_tx_pkg::byte_t payload[$];
  logic              rx_bits[$];
  int                stuff_cnt;
  int                max_run;
  logic              eop_ok;

  usb_tx_top #(
    .ClkPerBit(ClkPerBit),
    .FifoDepth(FifoDepth)
  ) usb_tx_top_i (
    .clk_i, .rst_ni, .link_reset_i, .cfg_pinflip_i, .tx_osc_test_mode_i,
    .wr_valid_i, .wr_data_i, .wr_ready_o,
    .pkt_start_i, .pid_i, .pkt_end_o,
    .usb_oe_o, .usb_d_o, .usb_se0_o, .usb_dp_o, .usb_dn_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (pkt_end_o) end_pulses++;
  end

  //////////////////////////////
  // Checking and bookkeeping
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("Timeout while waiting: %s", what);
    $display("Errors found");
    $finish;
  endtask

  task automatic check_eq(input string field, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", test_name, field, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("Error in %s: %s", test_name, msg);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name  = name;
    test_err   = 0;
    end_pulses = 0;
  endtask

  task automatic finish_test();
    test_cnt++;
    if (test_err == 0) begin
      $display("[PASS] %s", test_name);
    end else begin
      test_fail++;
      $display("[DONE] %s with %0d failed checks", test_name, test_err);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic step(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic random_payload(input int len);
    payload.delete();
    repeat (len) begin
      payload.push_back(8'($urandom));
    end
  endtask

  task automatic push_payload();
    int t;
    foreach (payload[i]) begin
      wr_valid_i = 1'b1;
      wr_data_i  = payload[i];
      t = 0;
      @(negedge clk_i);
      while (!wr_ready_o) begin
        t++;
        if (t > WaitLimit) abort_run("wr_ready_o stayed low");
        @(negedge clk_i);
      end
      step(1);
    end
    wr_valid_i = 1'b0;
  endtask

  task automatic start_packet(input usb_tx_pkg::pid_t pid);
    pid_i       = pid;
    pkt_start_i = 1'b1;
    step(1);
    pkt_start_i = 1'b0;
  endtask

  task automatic wait_oe(input logic level);
    int t;
    t = 0;
    @(negedge clk_i);
    while (usb_oe_o !== level) begin
      t++;
      if (t > WaitLimit) abort_run("usb_oe_o did not change");
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Bus decoder and reference
  //////////////////////////////

  // Samples mid-bit, undoes NRZI and stuffing, stops at SE0
  task automatic decode_bus(input logic flip);
    logic dp;
    logic dn;
    logic prev;
    logic b;
    logic se0_again;
    int   ones;
    int   run;
    int   n;

    rx_bits.delete();
    stuff_cnt = 0;
    max_run   = 0;
    wait_oe(1'b1);
    repeat (2) @(negedge clk_i);
    prev = 1'b1;
    ones = 0;
    run  = 0;
    n    = 0;
    dp   = flip ? usb_dn_o : usb_dp_o;
    dn   = flip ? usb_dp_o : usb_dn_o;
    while (dp || dn) begin
      // No transition is a one
      b    = (dp == prev);
      prev = dp;
      run  = b ? run + 1 : 0;
      if (run > max_run) max_run = run;
      if (ones == 6) begin
        stuff_cnt++;
        ones = 0;
      end else begin
        rx_bits.push_back(b);
        ones = b ? ones + 1 : 0;
      end
      n++;
      if (n > 400) abort_run("no SE0 within 400 bit times");
      repeat (ClkPerBit) @(negedge clk_i);
      dp = flip ? usb_dn_o : usb_dp_o;
      dn = flip ? usb_dp_o : usb_dn_o;
    end
    repeat (ClkPerBit) @(negedge clk_i);
    se0_again = !usb_dp_o && !usb_dn_o;
    repeat (ClkPerBit) @(negedge clk_i);
    dp     = flip ? usb_dn_o : usb_dp_o;
    dn     = flip ? usb_dp_o : usb_dn_o;
    eop_ok = se0_again && dp && !dn && usb_oe_o;
  endtask

  function automatic usb_tx_pkg::byte_t rx_byte(input int k);
    usb_tx_pkg::byte_t b;
    for (int i = 0; i < 8; i++) begin
      b[i] = rx_bits[8 * k + i];
    end
    return b;
  endfunction

  // x^16 + x^15 + x^2 + 1 over the payload in wire order, preset to ones
  function automatic logic [15:0] crc16_of();
    logic [15:0] c;
    logic        fb;
    c = 16'hFFFF;
    foreach (payload[i]) begin
      for (int k = 0; k < 8; k++) begin
        fb = payload[i][k] ^ c[15];
        c  = {c[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    end
    return ~c;
  endfunction

  // Zeros a sender inserts into SYNC, PID, payload and CRC
  function automatic int expected_stuff_count(input usb_tx_pkg::pid_t pid);
    usb_tx_pkg::byte_t bytes[$];
    logic              bits[$];
    logic [15:0]       crc;
    int                ones;
    int                cnt;
    bytes.push_back(8'h80);
    bytes.push_back({~pid, pid});
    if (pid[1:0] == 2'b11) begin
      foreach (payload[i]) bytes.push_back(payload[i]);
    end
    foreach (bytes[i]) begin
      for (int k = 0; k < 8; k++) bits.push_back(bytes[i][k]);
    end
    if (pid[1:0] == 2'b11) begin
      crc = crc16_of();
      for (int k = 15; k >= 0; k--) bits.push_back(crc[k]);
    end
    ones = 0;
    cnt  = 0;
    foreach (bits[i]) begin
      ones = bits[i] ? ones + 1 : 0;
      if (ones == 6) begin
        cnt++;
        ones = 0;
      end
    end
    return cnt;
  endfunction

  task automatic check_packet(input usb_tx_pkg::pid_t pid);
    logic [15:0] crc_got;
    int          nbytes;
    int          base;
    nbytes = (pid[1:0] == 2'b11) ? payload.size() + 4 : 2;
    base   = 8 * (payload.size() + 2);
    check_eq("bit count", nbytes * 8, rx_bits.size());
    if (rx_bits.size() == nbytes * 8) begin
      check_eq("sync", 8'h80, rx_byte(0));
      check_eq("pid", {~pid, pid}, rx_byte(1));
      if (pid[1:0] == 2'b11) begin
        foreach (payload[i]) check_eq("payload", payload[i], rx_byte(i + 2));
        // CRC goes out MSB first
        for (int i = 0; i < 16; i++) begin
          crc_got[15 - i] = rx_bits[base + i];
        end
        check_eq("crc16", crc16_of(), crc_got);
      end
    end
    check_true(eop_ok, "EOP was not SE0, SE0, J");
  endtask

  task automatic run_packet(input usb_tx_pkg::pid_t pid, input logic flip);
    step(1);
    end_pulses = 0;
    push_payload();
    start_packet(pid);
    decode_bus(flip);
    wait_oe(1'b0);
    check_packet(pid);
    check_eq("pkt_end pulses", 1, end_pulses);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int               t;
    logic             prev_dp;
    usb_tx_pkg::pid_t pid;

    rst_ni             = 1'b0;
    link_reset_i       = 1'b0;
    cfg_pinflip_i      = 1'b0;
    tx_osc_test_mode_i = 1'b0;
    wr_valid_i         = 1'b0;
    wr_data_i          = '0;
    pkt_start_i        = 1'b0;
    pid_i              = '0;
    err_cnt            = 0;
    test_cnt           = 0;
    test_fail          = 0;
    void'($urandom(50));
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test("handshake");
    @(negedge clk_i);
    check_eq("oe after reset", 0, usb_oe_o);
    check_eq("se0 after reset", 0, usb_se0_o);
    check_eq("dp after reset", 1, usb_dp_o);
    check_eq("d after reset", 1, usb_d_o);
    check_eq("dn after reset", 0, usb_dn_o);
    check_eq("pkt_end after reset", 0, pkt_end_o);
    payload.delete();
    run_packet(4'h2, 1'b0);
    finish_test();

    begin_test("data_random");
    repeat (4) begin
      random_payload($urandom_range(8, 1));
      pid = ($urandom_range(1, 0) == 1) ? 4'hB : 4'h3;
      run_packet(pid, 1'b0);
      check_eq("wr_ready after packet", 1, wr_ready_o);
    end
    finish_test();

    begin_test("stuffing");
    payload.delete();
    repeat (4) payload.push_back(8'hFF);
    run_packet(4'h3, 1'b0);
    check_true(max_run <= 6, "line carried more than six ones in a row");
    check_eq("stuffed bits", expected_stuff_count(4'h3), stuff_cnt);
    finish_test();

    begin_test("pin_flip");
    step(1);
    cfg_pinflip_i = 1'b1;
    step(2);
    @(negedge clk_i);
    check_eq("idle dp flipped", 0, usb_dp_o);
    check_eq("idle dn flipped", 1, usb_dn_o);
    random_payload(3);
    run_packet(4'hB, 1'b1);
    step(1);
    cfg_pinflip_i = 1'b0;
    step(2);
    finish_test();

    // Constant toggle while the mode is set
    begin_test("osc_test");
    step(1);
    tx_osc_test_mode_i = 1'b1;
    wait_oe(1'b1);
    repeat (2) @(negedge clk_i);
    prev_dp = usb_dp_o;
    repeat (16) begin
      repeat (ClkPerBit) @(negedge clk_i);
      check_eq("osc oe", 1, usb_oe_o);
      check_eq("osc se0", 0, usb_se0_o);
      check_eq("osc dp toggle", !prev_dp, usb_dp_o);
      prev_dp = usb_dp_o;
    end
    step(1);
    tx_osc_test_mode_i = 1'b0;
    t = 0;
    @(negedge clk_i);
    while (usb_oe_o && t < 16 * ClkPerBit) begin
      t++;
      @(negedge clk_i);
    end
    check_true(!usb_oe_o, "usb_oe_o still high two byte times after test mode ended");
    finish_test();

    // Abort in the PID byte, leftover payload must be dropped
    begin_test("link_reset");
    random_payload(8);
    step(1);
    push_payload();
    start_packet(4'h3);
    wait_oe(1'b1);
    step(12 * ClkPerBit);
    link_reset_i = 1'b1;
    step(1);
    link_reset_i = 1'b0;
    @(negedge clk_i);
    check_eq("oe after link reset", 0, usb_oe_o);
    check_eq("dp after link reset", 1, usb_dp_o);
    check_eq("dn after link reset", 0, usb_dn_o);
    check_eq("se0 after link reset", 0, usb_se0_o);
    check_eq("pkt_end after link reset", 0, pkt_end_o);
    random_payload(2);
    run_packet(4'hB, 1'b0);
    finish_test();

    $display("%0d tests, %0d failed tests, %0d failed checks", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== usb_fs_tx.sv ====
//////////////////////////////
// Full-speed packet serializer: SYNC, PID, payload, CRC16, EOP
// Pulls payload until the buffer runs dry, there is no wire back-pressure
// pkt_start_i is legal only while idle
//////////////////////////////

`timescale 1ns/1ps

module usb_fs_tx (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               link_reset_i,
  input  logic               tx_osc_test_mode_i,
  input  logic               bit_strobe_i,
  input  logic               pkt_start_i,
  input  usb_tx_pkg::pid_t   pid_i,
  input  logic               tx_data_avail_i,
  input  usb_tx_pkg::byte_t  tx_data_i,
  output logic               tx_data_get_o,
  input  usb_tx_pkg::crc16_t crc16_i,
  output logic               crc_clear_o,
  output logic               crc_en_o,
  output logic               crc_bit_o,
  output logic               tx_bit_o,
  output logic               tx_oe_o,
  output logic               tx_se0_o,
  output logic               test_start_o,
  output logic               pkt_end_o
);

  typedef enum logic [2:0] {
    Idle, Sync, Pid, DataOrCrcHi, CrcLo, Eop, OscTest
  } state_e;

  state_e            state_q, state_d;
  usb_tx_pkg::pid_t  pid_q;
  usb_tx_pkg::byte_t data_sr_q, data_sr_d;
  usb_tx_pkg::byte_t oe_sr_q, oe_sr_d;
  usb_tx_pkg::byte_t se0_sr_q, se0_sr_d;
  logic              payload_q, payload_d;
  logic              byte_strobe_q, byte_strobe_d;
  logic [4:0]        hist_q, hist_d;
  logic [2:0]        bit_cnt_q, bit_cnt_d;
  logic              stuffed_q, stuffed_d;
  logic [5:0]        history;
  logic              bitstuff;

  // CRC bytes go out inverted and MSB first, so reverse them for the LSB-first shift
  function automatic usb_tx_pkg::byte_t crc_byte(input usb_tx_pkg::byte_t b);
    usb_tx_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = ~b[7 - i];
    end
    return r;
  endfunction

  // Six ones including the bit now on the wire
  assign history  = {data_sr_q[0], hist_q};
  assign bitstuff = &history;

  //////////////////////////////
  // Sequencing FSM
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    data_sr_d     = data_sr_q;
    oe_sr_d       = oe_sr_q;
    se0_sr_d      = se0_sr_q;
    payload_d     = payload_q;
    hist_d        = hist_q;
    bit_cnt_d     = bit_cnt_q;
    stuffed_d     = stuffed_q;
    test_start_o  = 1'b0;
    tx_data_get_o = 1'b0;

    unique case (state_q)
      Idle: begin
        if (tx_osc_test_mode_i) begin
          state_d      = OscTest;
          test_start_o = 1'b1;
        end else if (pkt_start_i) begin
          state_d = Sync;
        end
      end

      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = 8'h80;
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end

      Pid: begin
        if (byte_strobe_q) begin
          // Only data PIDs carry a payload and CRC
          state_d   = (pid_q[1:0] == 2'b11) ? DataOrCrcHi : Eop;
          data_sr_d = {~pid_q, pid_q};
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end

      DataOrCrcHi: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hFF;
          se0_sr_d = 8'h00;
          if (tx_data_avail_i) begin
            payload_d     = 1'b1;
            tx_data_get_o = 1'b1;
            data_sr_d     = tx_data_i;
          end else begin
            state_d   = CrcLo;
            payload_d = 1'b0;
            data_sr_d = crc_byte(crc16_i[15:8]);
          end
        end
      end

      CrcLo: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = crc_byte(crc16_i[7:0]);
          oe_sr_d   = 8'hFF;
          se0_sr_d  = 8'h00;
        end
      end

      Eop: begin
        if (byte_strobe_q) begin
          // SE0, SE0 and J, then the bus is released
          state_d   = Idle;
          data_sr_d = 8'h00;
          oe_sr_d   = 8'h07;
          se0_sr_d  = 8'h07;
        end
      end

      OscTest: begin
        if (byte_strobe_q) begin
          data_sr_d = 8'h00;
          se0_sr_d  = 8'h00;
          if (!tx_osc_test_mode_i) begin
            state_d = Idle;
            oe_sr_d = 8'h00;
          end else begin
            // All zeros makes the line toggle every bit
            oe_sr_d = 8'hFF;
          end
        end
      end

      default: state_d = Idle;
    endcase

    // Bit timing, shared by every state
    if (pkt_start_i) begin
      bit_cnt_d = 3'd0;
      hist_d    = 5'd0;
      payload_d = 1'b0;
      stuffed_d = 1'b0;
    end else if (bit_strobe_i) begin
      stuffed_d = bitstuff;
      hist_d    = history[5:1];
      if (bitstuff) begin
        // Hold the shift and put the stuffed zero in the head slot
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !pkt_start_i && (bit_cnt_q == 3'd0);

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      pid_q         <= '0;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      bit_cnt_q     <= '0;
      stuffed_q     <= 1'b0;
    end else if (link_reset_i) begin
      state_q       <= Idle;
      pid_q         <= '0;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      payload_q     <= 1'b0;
      byte_strobe_q <= 1'b0;
      hist_q        <= '0;
      bit_cnt_q     <= '0;
      stuffed_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      if (pkt_start_i) pid_q <= pid_i;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      payload_q     <= payload_d;
      byte_strobe_q <= byte_strobe_d;
      hist_q        <= hist_d;
      bit_cnt_q     <= bit_cnt_d;
      stuffed_q     <= stuffed_d;
    end
  end

  // Stuffed zeros are not part of the CRC
  assign crc_clear_o = pkt_start_i;
  assign crc_en_o    = bit_strobe_i && payload_q && !stuffed_q && !pkt_start_i;
  assign crc_bit_o   = data_sr_q[0];

  assign tx_bit_o  = data_sr_q[0];
  assign tx_oe_o   = oe_sr_q[0];
  assign tx_se0_o  = se0_sr_q[0];
  assign pkt_end_o = bit_strobe_i && (se0_sr_q[1:0] == 2'b01);

endmodule

// ==== usb_tx.f ====
usb_tx_pkg.sv
usb_tx_bit_strobe.sv
usb_tx_byte_fifo.sv
usb_tx_crc16.sv
usb_fs_tx.sv
usb_tx_line_drv.sv
usb_tx_top.sv
tb_usb_tx_top.sv

// ==== usb_tx_bit_strobe.sv ====
//////////////////////////////
// Local bit timing for 12 Mbit/s from the 48 MHz clock
// ClkPerBit must be 2 or more
//////////////////////////////

`timescale 1ns/1ps

module usb_tx_bit_strobe #(
  parameter int ClkPerBit = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  output logic bit_strobe_o
);

  localparam int CntW = (ClkPerBit > 1) ? $clog2(ClkPerBit) : 1;
  localparam logic [CntW-1:0] LastCnt = CntW'(ClkPerBit - 1);

  logic [CntW-1:0] cnt_q;
  logic            wrap;
  logic            strobe_q;

  assign wrap = (cnt_q == LastCnt);

  // Strobe is registered so it lands one clock after the wrap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      strobe_q <= 1'b0;
    end else if (link_reset_i) begin
      cnt_q    <= '0;
      strobe_q <= 1'b0;
    end else begin
      cnt_q    <= wrap ? '0 : cnt_q + 1'b1;
      strobe_q <= wrap;
    end
  end

  assign bit_strobe_o = strobe_q;

endmodule

// ==== usb_tx_byte_fifo.sv ====
//////////////////////////////
// Payload byte buffer, push on the user side, pull toward the serializer
// FifoDepth must be a power of two, 2 or more
//////////////////////////////

`timescale 1ns/1ps

module usb_tx_byte_fifo #(
  parameter int FifoDepth = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              link_reset_i,
  input  logic              wr_valid_i,
  input  usb_tx_pkg::byte_t wr_data_i,
  output logic              wr_ready_o,
  output logic              rd_avail_o,
  output usb_tx_pkg::byte_t rd_data_o,
  input  logic              rd_get_i
);

  localparam int AddrW = $clog2(FifoDepth);

  // Pointers carry one extra bit to tell full from empty
  typedef logic [AddrW:0] ptr_t;

  usb_tx_pkg::byte_t mem_q [FifoDepth];
  ptr_t              wr_ptr_q;
  ptr_t              rd_ptr_q;
  logic              full;
  logic              empty;
  logic              push;
  logic              pop;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[AddrW] != rd_ptr_q[AddrW]) &&
                 (wr_ptr_q[AddrW-1:0] == rd_ptr_q[AddrW-1:0]);

  assign push = wr_valid_i && !full;
  assign pop  = rd_get_i && !empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[AddrW-1:0]] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (link_reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign wr_ready_o = !full;
  assign rd_avail_o = !empty;
  assign rd_data_o  = mem_q[rd_ptr_q[AddrW-1:0]];

endmodule

// ==== usb_tx_crc16.sv ====
//////////////////////////////
// Serial CRC16, one bit per enable, MSB of the register is the output end
// Caller must skip stuffed bits and present payload bits in wire order
//////////////////////////////

`timescale 1ns/1ps

module usb_tx_crc16 (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               link_reset_i,
  input  logic               clear_i,
  input  logic               en_i,
  input  logic               bit_i,
  output usb_tx_pkg::crc16_t crc_o
);

  usb_tx_pkg::crc16_t crc_q;
  logic               feedback;

  assign feedback = bit_i ^ crc_q[15];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= usb_tx_pkg::CRC16_INIT;
    end else if (link_reset_i || clear_i) begin
      crc_q <= usb_tx_pkg::CRC16_INIT;
    end else if (en_i) begin
      // Shift left and fold the polynomial in when the feedback is set
      crc_q <= {crc_q[14:0], 1'b0} ^
               ({16{feedback}} & usb_tx_pkg::CRC16_POLY);
    end
  end

  assign crc_o = crc_q;

endmodule

// ==== usb_tx_line_drv.sv ====
//////////////////////////////
// NRZI line coding, EOP and registered pads
// Idle line is J, pin flip swaps D+ and D- on every pad output
//////////////////////////////

`timescale 1ns/1ps

module usb_tx_line_drv (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic cfg_pinflip_i,
  input  logic bit_strobe_i,
  input  logic pkt_start_i,
  input  logic test_start_i,
  input  logic tx_bit_i,
  input  logic tx_oe_i,
  input  logic tx_se0_i,
  output logic usb_oe_o,
  output logic usb_d_o,
  output logic usb_se0_o,
  output logic usb_dp_o,
  output logic usb_dn_o
);

  typedef enum logic [1:0] {OsIdle, OsWaitByte, OsTransmit} out_state_e;

  out_state_e state_q, state_d;
  logic       nrzi_en;
  logic       line_q, line_d;
  logic       se0_q, se0_d;
  logic       oe_q, oe_d;
  logic [2:0] eop_q, eop_d;
  logic       dp_d;
  logic       dn_d;

  // Wait for the serializer to present its first driven byte
  always_comb begin
    state_d = state_q;
    nrzi_en = 1'b0;
    unique case (state_q)
      OsIdle:     if (pkt_start_i || test_start_i) state_d = OsWaitByte;
      OsWaitByte: if (tx_oe_i) state_d = OsTransmit;
      OsTransmit: begin
        nrzi_en = 1'b1;
        if (bit_strobe_i && !tx_oe_i) state_d = OsIdle;
      end
      default:    state_d = OsIdle;
    endcase
  end

  always_comb begin
    line_d = line_q;
    se0_d  = se0_q;
    oe_d   = oe_q;
    eop_d  = eop_q;

    if (pkt_start_i || test_start_i) begin
      // Start from J so the first SYNC bit comes out as K
      line_d = 1'b1;
      eop_d  = 3'b100;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_d = tx_oe_i;
      if (tx_se0_i) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          line_d = 1'b1;
          se0_d  = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!tx_bit_i) begin
        line_d = !line_q;
      end
      // Undriven line rests at J
      if (!oe_d) line_d = 1'b1;
    end
  end

  assign dp_d = (cfg_pinflip_i ? ~line_d : line_d) & ~se0_d;
  assign dn_d = (cfg_pinflip_i ? line_d : ~line_d) & ~se0_d;

  //////////////////////////////
  // Registers and pads
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= OsIdle;
      line_q    <= 1'b1;
      se0_q     <= 1'b0;
      oe_q      <= 1'b0;
      eop_q     <= '0;
      usb_d_o   <= 1'b1;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= 1'b1;
      usb_dn_o  <= 1'b0;
    end else if (link_reset_i) begin
      state_q   <= OsIdle;
      line_q    <= 1'b1;
      se0_q     <= 1'b0;
      oe_q      <= 1'b0;
      eop_q     <= '0;
      usb_d_o   <= ~cfg_pinflip_i;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= ~cfg_pinflip_i;
      usb_dn_o  <= cfg_pinflip_i;
    end else begin
      state_q   <= state_d;
      line_q    <= line_d;
      se0_q     <= se0_d;
      oe_q      <= oe_d;
      eop_q     <= eop_d;
      // Single-ended D follows D+
      usb_d_o   <= dp_d;
      usb_se0_o <= se0_d;
      usb_dp_o  <= dp_d;
      usb_dn_o  <= dn_d;
    end
  end

  assign usb_oe_o = oe_q;

endmodule

// ==== usb_tx_pkg.sv ====
//////////////////////////////
// Shared types and CRC16 constants of the USB full-speed transmit path
// CRC16 follows the USB data packet rules, so the residue is sent inverted
//////////////////////////////

package usb_tx_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  // One payload byte or one byte of the serialized packet
  typedef logic [7:0] byte_t;

  // Packet identifier, sent as the nibble and then its complement
  typedef logic [3:0] pid_t;

  // CRC16 shift register contents
  typedef logic [15:0] crc16_t;

  //////////////////////////////
  // CRC16
  //////////////////////////////

  // x^16 + x^15 + x^2 + 1
  parameter crc16_t CRC16_POLY = 16'h8005;

  // Preset at the start of every packet
  parameter crc16_t CRC16_INIT = 16'hFFFF;

endpackage

// ==== usb_tx_top.sv ====
//////////////////////////////
// USB full-speed transmit path, 48 MHz clock, local bit timing
// Load the payload before pkt_start_i
//////////////////////////////

`timescale 1ns/1ps

module usb_tx_top #(
  parameter int ClkPerBit = 4,
  parameter int FifoDepth = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              link_reset_i,
  input  logic              cfg_pinflip_i,
  input  logic              tx_osc_test_mode_i,
  input  logic              wr_valid_i,
  input  usb_tx_pkg::byte_t wr_data_i,
  output logic              wr_ready_o,
  input  logic              pkt_start_i,
  input  usb_tx_pkg::pid_t  pid_i,
  output logic              pkt_end_o,
  output logic              usb_oe_o,
  output logic              usb_d_o,
  output logic              usb_se0_o,
  output logic              usb_dp_o,
  output logic              usb_dn_o
);

  logic               bit_strobe;
  logic               fifo_avail;
  usb_tx_pkg::byte_t  fifo_data;
  logic               fifo_get;
  usb_tx_pkg::crc16_t crc16;
  logic               crc_clear;
  logic               crc_en;
  logic               crc_bit;
  logic               tx_bit;
  logic               tx_oe;
  logic               tx_se0;
  logic               test_start;

  usb_tx_bit_strobe #(
    .ClkPerBit(ClkPerBit)
  ) usb_tx_bit_strobe_i (
    .clk_i, .rst_ni, .link_reset_i,
    .bit_strobe_o(bit_strobe)
  );

  usb_tx_byte_fifo #(
    .FifoDepth(FifoDepth)
  ) usb_tx_byte_fifo_i (
    .clk_i, .rst_ni, .link_reset_i,
    .wr_valid_i, .wr_data_i, .wr_ready_o,
    .rd_avail_o(fifo_avail), .rd_data_o(fifo_data), .rd_get_i(fifo_get)
  );

  usb_tx_crc16 usb_tx_crc16_i (
    .clk_i, .rst_ni, .link_reset_i,
    .clear_i(crc_clear), .en_i(crc_en), .bit_i(crc_bit), .crc_o(crc16)
  );

  usb_fs_tx usb_fs_tx_i (
    .clk_i, .rst_ni, .link_reset_i, .tx_osc_test_mode_i,
    .bit_strobe_i(bit_strobe), .pkt_start_i, .pid_i,
    .tx_data_avail_i(fifo_avail), .tx_data_i(fifo_data), .tx_data_get_o(fifo_get),
    .crc16_i(crc16), .crc_clear_o(crc_clear), .crc_en_o(crc_en), .crc_bit_o(crc_bit),
    .tx_bit_o(tx_bit), .tx_oe_o(tx_oe), .tx_se0_o(tx_se0),
    .test_start_o(test_start), .pkt_end_o
  );

  usb_tx_line_drv usb_tx_line_drv_i (
    .clk_i, .rst_ni, .link_reset_i, .cfg_pinflip_i,
    .bit_strobe_i(bit_strobe), .pkt_start_i, .test_start_i(test_start),
    .tx_bit_i(tx_bit), .tx_oe_i(tx_oe), .tx_se0_i(tx_se0),
    .usb_oe_o, .usb_d_o, .usb_se0_o, .usb_dp_o, .usb_dn_o
  );

endmodule
